//--- logic/memPkg.sv
`default_nettype none

package memPkg;

  // One word request from the single requester.
  // A zero wstrb is a read; any set bit writes the matching byte lane.
  typedef struct packed {
    logic        valid;
    logic        instr;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
  } memReq;

  // Response for the request sampled one cycle earlier.
  typedef struct packed {
    logic        ready;
    logic [31:0] rdata;
    logic        error;
  } memResp;

  // Decoded target of a request.
  typedef enum logic [1:0] {
    regionRom,
    regionRam,
    regionNone
  } memRegion;

  // The boot ROM covers 64 words from this base.
  localparam logic [31:0] romBase = 32'h0000_0000;

  // The data RAM starts here.
  // Its size comes from the depth parameter of the top level.
  localparam logic [31:0] ramBase = 32'h8000_0000;

endpackage

`default_nettype wire

//--- logic/bootRom.sv
`timescale 1ns/1ps
`default_nettype none

module bootRom (
  input  logic          clock,
  input  logic          arstN,
  input  memPkg::memReq romReq,
  output logic [31:0]   romData
);

  logic [5:0]  wordIdx;
  logic [31:0] romWord;

  assign wordIdx = romReq.addr[7:2];

  always_comb begin
    case (wordIdx)
      // Clear the integer registers with compressed loads of zero.
      6'h00: romWord = 32'h4101_4081;
      6'h01: romWord = 32'h4201_4181;
      6'h02: romWord = 32'h4301_4281;
      6'h03: romWord = 32'h4401_4381;
      6'h04: romWord = 32'h4501_4481;
      6'h05: romWord = 32'h4601_4581;
      6'h06: romWord = 32'h4701_4681;
      6'h07: romWord = 32'h4801_4781;
      6'h08: romWord = 32'h4901_4881;
      6'h09: romWord = 32'h4A01_4981;
      6'h0A: romWord = 32'h4B01_4A81;
      6'h0B: romWord = 32'h4C01_4B81;
      6'h0C: romWord = 32'h4D01_4C81;
      6'h0D: romWord = 32'h4E01_4D81;
      6'h0E: romWord = 32'h4F01_4E81;
      // Trap vector and status setup.
      6'h0F: romWord = 32'h62F9_4F81;
      6'h10: romWord = 32'h6082_8293;
      6'h11: romWord = 32'h3002_A073;
      6'h12: romWord = 32'hA073_42BD;
      6'h13: romWord = 32'h0297_3042;
      6'h14: romWord = 32'h8293_0000;
      6'h15: romWord = 32'h9073_01C2;
      // Copy loop moving the data block into RAM.
      6'h16: romWord = 32'h02B7_3052;
      6'h17: romWord = 32'h0337_0100;
      6'h18: romWord = 32'h4381_8000;
      6'h19: romWord = 32'h0008_0E37;
      6'h1A: romWord = 32'h42E1_A001;
      6'h1B: romWord = 32'h3420_2373;
      6'h1C: romWord = 32'hFE62_9CE3;
      6'h1D: romWord = 32'h0002_AE83;
      6'h1E: romWord = 32'h01D3_2023;
      6'h1F: romWord = 32'h0391_0311;
      6'h20: romWord = 32'h01C3_D463;
      6'h21: romWord = 32'h3020_0073;
      // Load the RAM base and jump there.
      6'h22: romWord = 32'h8000_00B7;
      6'h23: romWord = 32'h0000_8067;
      6'h24: romWord = 32'h0000_0000;
      6'h25: romWord = 32'h0000_0000;
      6'h26: romWord = 32'h0000_0000;
      6'h27: romWord = 32'h0000_0000;
      6'h28: romWord = 32'h0000_0000;
      6'h29: romWord = 32'h0000_0000;
      6'h2A: romWord = 32'h0000_0000;
      6'h2B: romWord = 32'h0000_0000;
      6'h2C: romWord = 32'h0000_0000;
      6'h2D: romWord = 32'h0000_0000;
      6'h2E: romWord = 32'h0000_0000;
      6'h2F: romWord = 32'h0000_0000;
      6'h30: romWord = 32'h0000_0000;
      6'h31: romWord = 32'h0000_0000;
      6'h32: romWord = 32'h0000_0000;
      6'h33: romWord = 32'h0000_0000;
      6'h34: romWord = 32'h0000_0000;
      6'h35: romWord = 32'h0000_0000;
      6'h36: romWord = 32'h0000_0000;
      6'h37: romWord = 32'h0000_0000;
      6'h38: romWord = 32'h0000_0000;
      6'h39: romWord = 32'h0000_0000;
      6'h3A: romWord = 32'h0000_0000;
      6'h3B: romWord = 32'h0000_0000;
      6'h3C: romWord = 32'h0000_0000;
      6'h3D: romWord = 32'h0000_0000;
      6'h3E: romWord = 32'h0000_0000;
      6'h3F: romWord = 32'h0000_0000;
    endcase
  end

  // The output register only loads on a request and holds otherwise.
  always_ff @(posedge clock or negedge arstN) begin
    if (!arstN) begin
      romData <= 32'h0;
    end else if (romReq.valid) begin
      romData <= romWord;
    end
  end

endmodule

`default_nettype wire

//--- logic/dataRam.sv
`timescale 1ns/1ps
`default_nettype none

module dataRam #(
  parameter int RamDepthLog2 = 10
) (
  input  logic          clock,
  input  memPkg::memReq ramReq,
  output logic [31:0]   ramData
);

  localparam int ramWords = 2 ** RamDepthLog2;

  logic [31:0]             ramArray [ramWords];
  logic [RamDepthLog2-1:0] wordIdx;
  logic                    isWrite;

  // Word index sits directly above the byte offset.
  assign wordIdx = ramReq.addr[RamDepthLog2+1:2];
  assign isWrite = (ramReq.wstrb != 4'b0000);

  // Byte lanes are updated independently according to the strobe.
  always_ff @(posedge clock) begin
    if (ramReq.valid && isWrite) begin
      for (int lane = 0; lane < 4; lane++) begin
        if (ramReq.wstrb[lane]) begin
          ramArray[wordIdx][8*lane +: 8] <= ramReq.wdata[8*lane +: 8];
        end
      end
    end
  end

  // Read data is registered and holds between reads.
  always_ff @(posedge clock) begin
    if (ramReq.valid && !isWrite) begin
      ramData <= ramArray[wordIdx];
    end
  end

endmodule

`default_nettype wire

//--- logic/memDecoder.sv
`timescale 1ns/1ps
`default_nettype none

module memDecoder #(
  parameter int RamDepthLog2 = 10
) (
  input  logic           clock,
  input  logic           arstN,
  input  memPkg::memReq  hostReq,
  output memPkg::memResp hostResp,
  output memPkg::memReq  romReq,
  output memPkg::memReq  ramReq,
  input  logic [31:0]    romData,
  input  logic [31:0]    ramData
);

  import memPkg::*;

  localparam logic [31:0] ramBytes = 32'd4 << RamDepthLog2;
  localparam logic [31:0] ramLimit = ramBase + ramBytes;

  memRegion region;
  logic     isWrite;
  logic     reqError;

  // Target whose data goes out in the next cycle.
  // Writes and errors leave it at regionNone so rdata reads zero.
  memRegion dataSelQ;
  logic     readyQ;
  logic     errorQ;

  always_comb begin
    if (hostReq.addr[31:8] == romBase[31:8]) begin
      region = regionRom;
    end else if ((hostReq.addr >= ramBase) && (hostReq.addr < ramLimit)) begin
      region = regionRam;
    end else begin
      region = regionNone;
    end
  end

  assign isWrite  = (hostReq.wstrb != 4'b0000);
  assign reqError = (region == regionNone) || ((region == regionRom) && isWrite);

  // Each target only sees valid for requests it must serve.
  always_comb begin
    romReq       = hostReq;
    romReq.valid = hostReq.valid && (region == regionRom) && !isWrite;
  end

  always_comb begin
    ramReq       = hostReq;
    ramReq.valid = hostReq.valid && (region == regionRam);
  end

  always_ff @(posedge clock or negedge arstN) begin
    if (!arstN) begin
      readyQ   <= 1'b0;
      errorQ   <= 1'b0;
      dataSelQ <= regionNone;
    end else begin
      readyQ <= hostReq.valid;
      errorQ <= hostReq.valid && reqError;
      if (hostReq.valid && !reqError && !isWrite) begin
        dataSelQ <= region;
      end else begin
        dataSelQ <= regionNone;
      end
    end
  end

  always_comb begin
    hostResp.ready = readyQ;
    hostResp.error = errorQ;
    case (dataSelQ)
      regionRom: hostResp.rdata = romData;
      regionRam: hostResp.rdata = ramData;
      default:   hostResp.rdata = 32'h0;
    endcase
  end

endmodule

`default_nettype wire

//--- logic/memSubsystem.sv
`timescale 1ns/1ps
`default_nettype none

module memSubsystem #(
  parameter int RamDepthLog2 = 10
) (
  input  logic           clock,
  input  logic           arstN,
  input  memPkg::memReq  hostReq,
  output memPkg::memResp hostResp
);

  import memPkg::*;

  memReq       romReq;
  memReq       ramReq;
  logic [31:0] romData;
  logic [31:0] ramData;

  // All steering and error decisions live in the decoder.
  memDecoder #(
    .RamDepthLog2(RamDepthLog2)
  ) memDecoder_i (
    .clock    (clock),
    .arstN    (arstN),
    .hostReq  (hostReq),
    .hostResp (hostResp),
    .romReq   (romReq),
    .ramReq   (ramReq),
    .romData  (romData),
    .ramData  (ramData)
  );

  bootRom bootRom_i (
    .clock   (clock),
    .arstN   (arstN),
    .romReq  (romReq),
    .romData (romData)
  );

  dataRam #(
    .RamDepthLog2(RamDepthLog2)
  ) dataRam_i (
    .clock   (clock),
    .ramReq  (ramReq),
    .ramData (ramData)
  );

endmodule

`default_nettype wire

//--- bench/memSubsystem_chk.sv
`timescale 1ns/1ps
`default_nettype none

module memSubsystem_chk (
  input logic           clock,
  input logic           arstN,
  input memPkg::memReq  hostReq,
  input memPkg::memResp hostResp
);

  // Every request gets exactly one ready, one cycle later.
  readyFollowsValid: assert property (
    @(posedge clock) disable iff (!arstN)
    hostResp.ready == $past(hostReq.valid)
  ) else $error("ready does not match valid of the previous cycle");

  // Error responses carry no data.
  errorHasNoData: assert property (
    @(posedge clock) disable iff (!arstN)
    hostResp.error |-> (hostResp.rdata == 32'h0)
  ) else $error("rdata is nonzero on an error response");

  readyLowInReset: assert property (
    @(posedge clock)
    !arstN |-> !hostResp.ready
  ) else $error("ready is high during reset");

endmodule

bind memSubsystem memSubsystem_chk memSubsystem_chk_i (
  .clock    (clock),
  .arstN    (arstN),
  .hostReq  (hostReq),
  .hostResp (hostResp)
);

`default_nettype wire

//--- bench/memSubsystemTb.sv
`timescale 1ns/1ps
`default_nettype none

module memSubsystemTb;

  import memPkg::*;

  localparam int ramDepthLog2 = 10;
  localparam int ramWords = 2 ** ramDepthLog2;
  localparam logic [31:0] ramBytes = 32'd4 << ramDepthLog2;
  localparam int tableRows = 27;
  localparam int randOps = 200;
  // Each random write may be followed by one read.
  localparam int watchdogNs = (tableRows + 2 * randOps + 40) * 100;

  typedef struct packed {
    logic [2:0]  group;
    logic        valid;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic [31:0] expRdata;
    logic        expError;
  } stimRow;

  logic   clock;
  logic   arstN;
  memReq  hostReq;
  memResp hostResp;

  stimRow      stimTable [tableRows];
  logic [31:0] modelData [ramWords];
  logic [31:0] modelKnown [ramWords];
  int unsigned written [$];

  // Expectation for the request that the DUT sampled at the last edge.
  logic        pendValid;
  logic [31:0] pendRdata;
  logic [31:0] pendMask;
  logic        pendError;

  int errorCount;
  int checkCount;
  int testCount;

  memSubsystem #(
    .RamDepthLog2(ramDepthLog2)
  ) memSubsystem_i (
    .clock    (clock),
    .arstN    (arstN),
    .hostReq  (hostReq),
    .hostResp (hostResp)
  );

  initial clock = 1'b0;
  always #50 clock = ~clock;

  task automatic loadTable();
    // ROM reads of boot program words.
    stimTable[0]  = '{3'd1, 1'b1, 32'h0000_0000, 32'h0, 4'h0, 32'h4101_4081, 1'b0};
    stimTable[1]  = '{3'd1, 1'b1, 32'h0000_003C, 32'h0, 4'h0, 32'h62F9_4F81, 1'b0};
    stimTable[2]  = '{3'd1, 1'b1, 32'h0000_0044, 32'h0, 4'h0, 32'h3002_A073, 1'b0};
    stimTable[3]  = '{3'd1, 1'b1, 32'h0000_008C, 32'h0, 4'h0, 32'h0000_8067, 1'b0};
    stimTable[4]  = '{3'd1, 1'b1, 32'h0000_00C0, 32'h0, 4'h0, 32'h0000_0000, 1'b0};
    // RAM writes with partial strobes, merged bytes read back.
    stimTable[5]  = '{3'd2, 1'b1, 32'h8000_0010, 32'h1122_3344, 4'hF, 32'h0, 1'b0};
    stimTable[6]  = '{3'd2, 1'b1, 32'h8000_0010, 32'hDEAD_BEEF, 4'h2, 32'h0, 1'b0};
    stimTable[7]  = '{3'd2, 1'b1, 32'h8000_0010, 32'hCAFE_0000, 4'hC, 32'h0, 1'b0};
    stimTable[8]  = '{3'd2, 1'b1, 32'h8000_0010, 32'h0, 4'h0, 32'hCAFE_BE44, 1'b0};
    stimTable[9]  = '{3'd2, 1'b1, 32'h8000_0FFC, 32'h0102_0304, 4'hF, 32'h0, 1'b0};
    stimTable[10] = '{3'd2, 1'b1, 32'h8000_0FFC, 32'h9A00_0000, 4'h8, 32'h0, 1'b0};
    stimTable[11] = '{3'd2, 1'b1, 32'h8000_0FFC, 32'h0, 4'h0, 32'h9A02_0304, 1'b0};
    stimTable[12] = '{3'd2, 1'b1, 32'h8000_0010, 32'h0, 4'h0, 32'hCAFE_BE44, 1'b0};
    // Unmapped accesses and a write to the ROM.
    stimTable[13] = '{3'd3, 1'b1, 32'h4000_0000, 32'h0, 4'h0, 32'h0, 1'b1};
    stimTable[14] = '{3'd3, 1'b1, 32'h4000_0000, 32'h1234_5678, 4'hF, 32'h0, 1'b1};
    stimTable[15] = '{3'd3, 1'b1, 32'h8000_1000, 32'h0, 4'h0, 32'h0, 1'b1};
    stimTable[16] = '{3'd3, 1'b1, 32'h0000_0100, 32'h0, 4'h0, 32'h0, 1'b1};
    stimTable[17] = '{3'd3, 1'b1, 32'h0000_0044, 32'hFFFF_FFFF, 4'hF, 32'h0, 1'b1};
    stimTable[18] = '{3'd3, 1'b1, 32'h0000_0044, 32'h0, 4'h0, 32'h3002_A073, 1'b0};
    // Mixed targets back to back, with idle gaps.
    stimTable[19] = '{3'd4, 1'b1, 32'h0000_0000, 32'h0, 4'h0, 32'h4101_4081, 1'b0};
    stimTable[20] = '{3'd4, 1'b0, 32'h0000_0000, 32'h0, 4'h0, 32'h0, 1'b0};
    stimTable[21] = '{3'd4, 1'b1, 32'h8000_0010, 32'h0, 4'h0, 32'hCAFE_BE44, 1'b0};
    stimTable[22] = '{3'd4, 1'b0, 32'h0000_0000, 32'h0, 4'h0, 32'h0, 1'b0};
    stimTable[23] = '{3'd4, 1'b0, 32'h0000_0000, 32'h0, 4'h0, 32'h0, 1'b0};
    stimTable[24] = '{3'd4, 1'b1, 32'hFFFF_FFF0, 32'h0, 4'h0, 32'h0, 1'b1};
    stimTable[25] = '{3'd4, 1'b1, 32'h0000_008C, 32'h0, 4'h0, 32'h0000_8067, 1'b0};
    stimTable[26] = '{3'd4, 1'b1, 32'h8000_0FFC, 32'h0, 4'h0, 32'h9A02_0304, 1'b0};
  endtask

  // The model follows every RAM write byte by byte and marks those bytes known.
  task automatic updateModel(input memReq req);
    logic [ramDepthLog2-1:0] idx;
    idx = req.addr[ramDepthLog2+1:2];
    if (req.valid && (req.wstrb != 4'h0) && (req.addr >= ramBase) &&
        (req.addr < ramBase + ramBytes)) begin
      for (int lane = 0; lane < 4; lane++) begin
        if (req.wstrb[lane]) begin
          modelData[idx][8*lane +: 8] = req.wdata[8*lane +: 8];
          modelKnown[idx][8*lane +: 8] = 8'hFF;
        end
      end
    end
  endtask

  task automatic checkPending();
    checkCount++;
    assert (hostResp.ready === pendValid) else begin
      $display("ERROR at %0t: hostResp.ready is %0b, expected %0b",
               $time, hostResp.ready, pendValid);
      errorCount++;
    end
    if (pendValid) begin
      assert (hostResp.error === pendError) else begin
        $display("ERROR at %0t: hostResp.error is %0b, expected %0b",
                 $time, hostResp.error, pendError);
        errorCount++;
      end
      assert ((hostResp.rdata & pendMask) === (pendRdata & pendMask)) else begin
        $display("ERROR at %0t: hostResp.rdata is %08h, expected %08h",
                 $time, hostResp.rdata, pendRdata & pendMask);
        errorCount++;
      end
    end
  endtask

  // Drives one request and checks the response to the one before it.
  task automatic stepCycle(input memReq req, input logic [31:0] expRdata,
                           input logic [31:0] expMask, input logic expError);
    @(posedge clock);
    hostReq <= req;
    updateModel(req);
    @(negedge clock);
    checkPending();
    pendValid = req.valid;
    pendRdata = expRdata;
    pendMask  = expMask;
    pendError = expError;
  endtask

  task automatic reportTest(input string name, input int reqs, input int startErrors);
    testCount++;
    $display("test %-10s %4d requests, %0d errors", name, reqs, errorCount - startErrors);
  endtask

  task automatic runGroup(input logic [2:0] grp, input string name);
    int    startErrors;
    int    reqs;
    int    r;
    memReq req;
    memReq idle;
    startErrors = errorCount;
    reqs = 0;
    idle = '0;
    for (r = 0; r < tableRows; r++) begin
      if (stimTable[r].group == grp) begin
        req = '0;
        req.valid = stimTable[r].valid;
        req.addr  = stimTable[r].addr;
        req.wdata = stimTable[r].wdata;
        req.wstrb = stimTable[r].wstrb;
        stepCycle(req, stimTable[r].expRdata, 32'hFFFF_FFFF, stimTable[r].expError);
        if (req.valid) begin
          reqs++;
        end
      end
    end
    stepCycle(idle, 32'h0, 32'h0, 1'b0);
    reportTest(name, reqs, startErrors);
  endtask

  task automatic runRandom();
    int          startErrors;
    int          reqs;
    int unsigned wordSel;
    int unsigned pick;
    memReq       req;
    memReq       idle;
    startErrors = errorCount;
    reqs = 0;
    idle = '0;
    for (int n = 0; n < randOps; n++) begin
      wordSel = $urandom_range(63, 0);
      req = '0;
      req.valid = 1'b1;
      req.addr  = ramBase + (wordSel << 2);
      req.wdata = $urandom();
      req.wstrb = 4'($urandom_range(15, 1));
      written.push_back(wordSel);
      stepCycle(req, 32'h0, 32'hFFFF_FFFF, 1'b0);
      reqs++;
      if ($urandom_range(1, 0) == 1) begin
        pick = written[$urandom_range(written.size() - 1, 0)];
        req = '0;
        req.valid = 1'b1;
        req.addr  = ramBase + (pick << 2);
        // Bytes never written are unknown in the RAM and are left out of the compare.
        stepCycle(req, modelData[pick], modelKnown[pick], 1'b0);
        reqs++;
      end
    end
    stepCycle(idle, 32'h0, 32'h0, 1'b0);
    reportTest("random", reqs, startErrors);
  endtask

  initial begin
    int startErrors;
    hostReq <= '0;
    arstN   <= 1'b0;
    void'($urandom(60));
    errorCount = 0;
    checkCount = 0;
    testCount  = 0;
    pendValid  = 1'b0;
    pendRdata  = 32'h0;
    pendMask   = 32'h0;
    pendError  = 1'b0;
    for (int w = 0; w < ramWords; w++) begin
      modelData[w]  = 32'h0;
      modelKnown[w] = 32'h0;
    end
    loadTable();

    startErrors = errorCount;
    repeat (16) begin
      @(negedge clock);
      checkCount++;
      assert (hostResp.ready === 1'b0) else begin
        $display("ERROR at %0t: hostResp.ready is %0b, expected 0 in reset",
                 $time, hostResp.ready);
        errorCount++;
      end
    end
    @(posedge clock);
    arstN <= 1'b1;
    reportTest("reset", 0, startErrors);

    runGroup(3'd1, "romRead");
    runGroup(3'd2, "ramStrobe");
    runGroup(3'd3, "errors");
    runGroup(3'd4, "timing");
    runRandom();

    $display("%0d tests, %0d checks, %0d errors", testCount, checkCount, errorCount);
    if (errorCount == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

  initial begin
    #(watchdogNs);
    $display("Watchdog expired before the tests finished");
    $display("TB FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- project.f
logic/memPkg.sv
logic/bootRom.sv
logic/dataRam.sv
logic/memDecoder.sv
logic/memSubsystem.sv
bench/memSubsystem_chk.sv
bench/memSubsystemTb.sv

//--- run.sh
#!/bin/sh
# Builds and runs the memory subsystem testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f project.f --top-module memSubsystemTb -o simv
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

output=$(./obj_dir/simv)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -q "^TB PASSED$"; then
  exit 0
fi

echo "Pass message not found in simulation output"
exit 1
